// ==== build.f ====
src/cnn_pkg.sv
src/weight_bus_if.sv
src/weight_ram.sv
src/weight_arbiter.sv
src/line_buffer.sv
src/conv_engine.sv
src/cnn_conv_top.sv
dv/cnn_conv_assertions.sv
dv/cnn_conv_tb.sv

// ==== dv/cnn_conv_assertions.sv ====
// CNN conv assertions: arbiter grant rules and output timing against kernel loading
`timescale 1ns/100ps
`default_nettype none

module cnn_conv_assertions
    import cnn_pkg::*;
(
    input wire logic                   clock_i,
    input wire logic                   rst_i,
    // Arbiter side
    input wire logic [NUM_ENGINES-1:0] gnt_i,
    input wire logic [NUM_ENGINES-1:0] req_i,
    // Top-level outputs
    input wire logic                   busy_i,
    input wire logic                   out_valid_i
);

    // At most one engine reaches the RAM per cycle
    grant_onehot: assert property (@(posedge clock_i) disable iff (rst_i)
        $onehot0(gnt_i))
        else $error("grant vector not one-hot");

    // Grant only to a requester
    grant_has_req: assert property (@(posedge clock_i) disable iff (rst_i)
        (gnt_i & ~req_i) == '0)
        else $error("grant without request");

    // Host keeps pixels away during a load
    no_result_busy: assert property (@(posedge clock_i) disable iff (rst_i)
        !(out_valid_i && busy_i))
        else $error("result strobe during kernel load");

    // Loader idle right out of reset
    idle_after_reset: assert property (@(posedge clock_i)
        rst_i |=> !busy_i)
        else $error("busy high after reset");

endmodule

// Arbiter grant and request vectors reached from the top level scope
bind cnn_conv_top cnn_conv_assertions u_assertions (
    .clock_i     (clock_i),
    .rst_i       (rst_i),
    .gnt_i       (u_weight_arbiter.gnt),
    .req_i       (u_weight_arbiter.req_vec),
    .busy_i      (busy_o),
    .out_valid_i (out_valid_o)
);

`default_nettype wire

// ==== dv/cnn_conv_tb.sv ====
// CNN conv testbench: random frames and kernels checked against a convolution model
`timescale 1ns/100ps
`default_nettype none

module cnn_conv_tb
    import cnn_pkg::*;
;

    localparam int IMG_W         = 8;
    localparam int IMG_H         = 6;
    localparam int SHIFT         = 4;
    localparam int NUM_WEIGHTS   = NUM_ENGINES * NUM_TAPS;
    localparam int RESULTS_FRAME = (IMG_W - 2) * (IMG_H - 2);
    localparam int BUSY_TIMEOUT  = 100;
    localparam int DRAIN_TIMEOUT = 20;

    logic                            clock_i;
    logic                            rst_i;
    logic [PIX_BITS-1:0]             pix_i;
    logic                            pix_valid_i;
    logic                            wt_we_i;
    logic [WT_ADDR_BITS-1:0]         wt_addr_i;
    logic signed [WT_BITS-1:0]       wt_data_i;
    logic                            load_i;
    logic                            busy_o;
    logic [NUM_ENGINES*PIX_BITS-1:0] out_pix_o;
    logic                            out_valid_o;

    // Model state
    logic signed [WT_BITS-1:0] wt_model [NUM_WEIGHTS];
    logic [PIX_BITS-1:0]       frame_pix [IMG_H][IMG_W];
    logic [15:0]               exp_pix_q [$];
    int                        exp_cyc_q [$];
    logic [15:0]               lfsr_q;
    int                        cycle_cnt;
    int                        result_cnt;
    int                        frame_cnt;

    cnn_conv_top #(
        .IMG_WIDTH  (IMG_W),
        .IMG_HEIGHT (IMG_H),
        .Q_SHIFT    (SHIFT)
    ) dut0 (
        .clock_i     (clock_i),
        .rst_i       (rst_i),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .wt_we_i     (wt_we_i),
        .wt_addr_i   (wt_addr_i),
        .wt_data_i   (wt_data_i),
        .load_i      (load_i),
        .busy_o      (busy_o),
        .out_pix_o   (out_pix_o),
        .out_valid_o (out_valid_o)
    );

    // 20 ns clock
    initial begin
        clock_i = 1'b0;
        forever #10 clock_i = ~clock_i;
    end

    // Posedge count, read only on the falling edge
    initial cycle_cnt = 0;
    always @(posedge clock_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[6:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // Both channels for the window ending at (r, c)
    function automatic logic [15:0] model_result(input int r, input int c);
        logic [15:0] res;
        int          acc;
        int          scaled;
        res = '0;
        for (int ch = 0; ch < NUM_ENGINES; ch++) begin
            acc = 0;
            for (int kr = 0; kr < KSIZE; kr++) begin
                for (int kc = 0; kc < KSIZE; kc++) begin
                    acc = acc + int'(frame_pix[r-2+kr][c-2+kc]) *
                          int'(wt_model[ch*NUM_TAPS + kr*KSIZE + kc]);
                end
            end
            // ReLU, then the fixed-point shift, then clamp to a byte
            if (acc < 0) begin
                scaled = 0;
            end else begin
                scaled = acc >>> SHIFT;
                if (scaled > 255) begin
                    scaled = 255;
                end
            end
            res[ch*8 +: 8] = scaled[7:0];
        end
        return res;
    endfunction

    // Mode 0 random, 1 all -128, 2 all 127
    task automatic write_weights(input int mode);
        logic [7:0] v;
        for (int i = 0; i < NUM_WEIGHTS; i++) begin
            if (mode == 0) begin
                rand_bits(8, v);
            end else if (mode == 1) begin
                v = 8'h80;
            end else begin
                v = 8'h7f;
            end
            @(negedge clock_i);
            wt_we_i     = 1'b1;
            wt_addr_i   = WT_ADDR_BITS'(i);
            wt_data_i   = v;
            wt_model[i] = v;
        end
        @(negedge clock_i);
        wt_we_i = 1'b0;
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (busy_o && n < BUSY_TIMEOUT) begin
            @(negedge clock_i);
            n++;
        end
        if (busy_o) begin
            fail_run("Timeout: busy_o stayed high after the kernel load");
        end
    endtask

    // Busy must be up one cycle after the pulse
    task automatic load_kernels();
        @(negedge clock_i);
        load_i = 1'b1;
        @(negedge clock_i);
        load_i = 1'b0;
        check_value("busy_o", busy_o, 1);
        wait_busy_low();
    endtask

    // Gap mode adds random idle cycles, pix mode 1 drives 255 everywhere
    task automatic send_frame(input bit gaps, input int pix_mode);
        logic [7:0] v;
        logic [7:0] gap;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                if (gaps) begin
                    rand_bits(1, gap);
                    if (gap[0]) begin
                        @(negedge clock_i);
                        pix_valid_i = 1'b0;
                    end
                end
                if (pix_mode == 0) begin
                    rand_bits(8, v);
                end else begin
                    v = 8'hff;
                end
                @(negedge clock_i);
                pix_valid_i     = 1'b1;
                pix_i           = v;
                frame_pix[r][c] = v;
                if (r >= KSIZE - 1 && c >= KSIZE - 1) begin
                    exp_pix_q.push_back(model_result(r, c));
                    // Strobe taken at the next posedge, result 3 edges on
                    exp_cyc_q.push_back(cycle_cnt + 3);
                end
            end
        end
        @(negedge clock_i);
        pix_valid_i = 1'b0;
        frame_cnt++;
    endtask

    task automatic drain_results();
        int n;
        n = 0;
        while (exp_pix_q.size() != 0 && n < DRAIN_TIMEOUT) begin
            @(negedge clock_i);
            n++;
        end
        if (exp_pix_q.size() != 0) begin
            fail_run("Timeout: expected results never came out");
        end
    endtask

    // Result monitor, outputs stable on the falling edge
    always @(negedge clock_i) begin
        if (!rst_i && out_valid_o) begin
            if (exp_pix_q.size() == 0) begin
                fail_run("Unexpected result strobe with nothing pending");
            end else begin
                check_value("out_pix_o", out_pix_o, exp_pix_q[0]);
                check_value("out_valid_o cycle", cycle_cnt, exp_cyc_q[0]);
                void'(exp_pix_q.pop_front());
                void'(exp_cyc_q.pop_front());
                result_cnt++;
            end
        end
    end

    initial begin
        rst_i       = 1'b1;
        pix_i       = '0;
        pix_valid_i = 1'b0;
        wt_we_i     = 1'b0;
        wt_addr_i   = '0;
        wt_data_i   = '0;
        load_i      = 1'b0;
        lfsr_q      = 16'd29;
        result_cnt  = 0;
        frame_cnt   = 0;
        repeat (8) @(negedge clock_i);
        rst_i = 1'b0;
        @(negedge clock_i);

        // Random kernels, two frames back to back
        write_weights(0);
        load_kernels();
        send_frame(1'b0, 0);
        send_frame(1'b0, 0);
        drain_results();

        // New kernels, frame with idle gaps
        write_weights(0);
        load_kernels();
        send_frame(1'b1, 0);
        drain_results();

        // Every sum negative
        write_weights(1);
        load_kernels();
        send_frame(1'b0, 0);
        drain_results();

        // Largest positive sum saturates
        write_weights(2);
        load_kernels();
        send_frame(1'b1, 1);
        drain_results();

        repeat (4) @(negedge clock_i);
        if (result_cnt != frame_cnt * RESULTS_FRAME || exp_pix_q.size() != 0) begin
            fail_run($sformatf("Result count %0d does not match %0d frames",
                               result_cnt, frame_cnt));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src/cnn_conv_top.sv ====
// CNN conv top: streaming 3x3 convolution with two output channels and shared weights
`timescale 1ns/100ps
`default_nettype none

module cnn_conv_top
    import cnn_pkg::*;
#(
    parameter int IMG_WIDTH  = 8,
    parameter int IMG_HEIGHT = 6,
    parameter int Q_SHIFT    = 4
) (
    input  logic                            clock_i,
    input  logic                            rst_i,
    // Pixel stream
    input  logic [PIX_BITS-1:0]             pix_i,
    input  logic                            pix_valid_i,
    // Host weight writes
    input  logic                            wt_we_i,
    input  logic [WT_ADDR_BITS-1:0]         wt_addr_i,
    input  logic signed [WT_BITS-1:0]       wt_data_i,
    // Kernel load
    input  logic                            load_i,
    output logic                            busy_o,
    // Channel 1 in the upper byte
    output logic [NUM_ENGINES*PIX_BITS-1:0] out_pix_o,
    output logic                            out_valid_o
);

    pix_window_t               window;
    logic                      window_valid;
    logic [WT_ADDR_BITS-1:0]   ram_raddr;
    logic signed [WT_BITS-1:0] ram_rdata;
    logic [NUM_ENGINES-1:0]    eng_busy;
    logic [NUM_ENGINES-1:0]    eng_valid;
    logic [PIX_BITS-1:0]       eng_result [NUM_ENGINES];

    // One read bus per engine
    weight_bus_if wbus [NUM_ENGINES] ();

    line_buffer #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_line_buffer (
        .clock_i        (clock_i),
        .rst_i          (rst_i),
        .pix_i          (pix_i),
        .pix_valid_i    (pix_valid_i),
        .window_o       (window),
        .window_valid_o (window_valid)
    );

    weight_ram u_weight_ram (
        .clock_i (clock_i),
        .rst_i   (rst_i),
        .we_i    (wt_we_i),
        .waddr_i (wt_addr_i),
        .wdata_i (wt_data_i),
        .raddr_i (ram_raddr),
        .rdata_o (ram_rdata)
    );

    weight_arbiter u_weight_arbiter (
        .clock_i     (clock_i),
        .rst_i       (rst_i),
        .bus         (wbus),
        .ram_raddr_o (ram_raddr),
        .ram_rdata_i (ram_rdata)
    );

    // Engines run in lockstep on the same window
    for (genvar e = 0; e < NUM_ENGINES; e++) begin : g_engine
        conv_engine #(
            .CHANNEL (e),
            .Q_SHIFT (Q_SHIFT)
        ) u_conv_engine (
            .clock_i        (clock_i),
            .rst_i          (rst_i),
            .load_i         (load_i),
            .busy_o         (eng_busy[e]),
            .bus            (wbus[e]),
            .window_i       (window),
            .window_valid_i (window_valid),
            .result_o       (eng_result[e]),
            .result_valid_o (eng_valid[e])
        );
        assign out_pix_o[e*PIX_BITS +: PIX_BITS] = eng_result[e];
    end

    assign busy_o      = |eng_busy;
    assign out_valid_o = eng_valid[0];

endmodule

`default_nettype wire

// ==== src/cnn_pkg.sv ====
// CNN conv package: widths, kernel geometry, pixel window type and engine loader states
`default_nettype none

package cnn_pkg;

    // Pixel and weight widths
    localparam int PIX_BITS = 8;
    localparam int WT_BITS  = 8;

    // Kernel geometry, square 3x3
    localparam int KSIZE    = 3;
    localparam int NUM_TAPS = KSIZE * KSIZE;

    // One engine per output channel
    localparam int NUM_ENGINES = 2;

    // Weight address = channel * NUM_TAPS + row * KSIZE + col
    localparam int WT_ADDR_BITS = 5;

    // Signed accumulator, holds nine 17-bit products
    localparam int ACC_BITS = 20;

    // Window in tap order, tap 0 is the oldest row, leftmost column
    typedef logic [NUM_TAPS-1:0][PIX_BITS-1:0] pix_window_t;

    // Weight loader states
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_REQ,
        ENG_WAIT
    } engine_state_e;

endpackage

`default_nettype wire

// ==== src/conv_engine.sv ====
// Conv engine: weight loader FSM and two-stage MAC with ReLU, shift and saturation
`timescale 1ns/100ps
`default_nettype none

module conv_engine
    import cnn_pkg::*;
#(
    parameter int CHANNEL = 0,
    parameter int Q_SHIFT = 4
) (
    input  logic                clock_i,
    input  logic                rst_i,
    // Weight load control
    input  logic                load_i,
    output logic                busy_o,
    weight_bus_if.requester     bus,
    // Window stream from the line buffer
    input  pix_window_t         window_i,
    input  logic                window_valid_i,
    // Activation output
    output logic [PIX_BITS-1:0] result_o,
    output logic                result_valid_o
);

    // Unsigned pixel times signed weight
    localparam int PROD_BITS = PIX_BITS + WT_BITS + 1;
    localparam int TAP_BITS  = $clog2(NUM_TAPS);
    localparam int BASE_ADDR = CHANNEL * NUM_TAPS;

    engine_state_e               state_q;
    logic [TAP_BITS-1:0]         tap_q;
    logic signed [WT_BITS-1:0]   weight_q [NUM_TAPS];

    logic signed [PROD_BITS-1:0] prod_q [NUM_TAPS];
    logic                        prod_valid_q;
    logic signed [ACC_BITS-1:0]  acc;
    logic signed [ACC_BITS-1:0]  acc_shifted;
    logic [PIX_BITS-1:0]         act;
    logic [PIX_BITS-1:0]         result_q;
    logic                        result_valid_q;

    // Request the current tap at this channel's base
    assign bus.req  = (state_q == ENG_REQ);
    assign bus.addr = WT_ADDR_BITS'(BASE_ADDR) + WT_ADDR_BITS'(tap_q);
    assign busy_o   = (state_q != ENG_IDLE);

    // Loader, one tap per grant and return
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            state_q <= ENG_IDLE;
            tap_q   <= '0;
        end else begin
            case (state_q)
                ENG_IDLE: begin
                    if (load_i) begin
                        state_q <= ENG_REQ;
                        tap_q   <= '0;
                    end
                end
                ENG_REQ: begin
                    // Served this cycle, data next cycle
                    if (bus.gnt) begin
                        state_q <= ENG_WAIT;
                    end
                end
                ENG_WAIT: begin
                    if (bus.rvalid) begin
                        if (tap_q == TAP_BITS'(NUM_TAPS - 1)) begin
                            state_q <= ENG_IDLE;
                        end else begin
                            tap_q   <= tap_q + 1'b1;
                            state_q <= ENG_REQ;
                        end
                    end
                end
                default: state_q <= ENG_IDLE;
            endcase
        end
    end

    // Local kernel copy
    always_ff @(posedge clock_i) begin
        if ((state_q == ENG_WAIT) && bus.rvalid) begin
            weight_q[tap_q] <= bus.rdata;
        end
    end

    // Stage 1, nine signed products
    always_ff @(posedge clock_i) begin
        for (int t = 0; t < NUM_TAPS; t++) begin
            prod_q[t] <= $signed({1'b0, window_i[t]}) * weight_q[t];
        end
    end

    // Adder tree feeding stage 2
    always_comb begin
        acc = '0;
        for (int t = 0; t < NUM_TAPS; t++) begin
            acc = acc + prod_q[t];
        end
    end

    // ReLU, fixed-point shift, clamp to 255
    assign acc_shifted = acc >>> Q_SHIFT;
    always_comb begin
        if (acc[ACC_BITS-1]) begin
            act = '0;
        end else if (|acc_shifted[ACC_BITS-1:PIX_BITS]) begin
            act = '1;
        end else begin
            act = acc_shifted[PIX_BITS-1:0];
        end
    end

    // Stage 2 result register
    always_ff @(posedge clock_i) begin
        result_q <= act;
    end

    // Valid follows the two stages
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            prod_valid_q   <= 1'b0;
            result_valid_q <= 1'b0;
        end else begin
            prod_valid_q   <= window_valid_i;
            result_valid_q <= prod_valid_q;
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = result_valid_q;

endmodule

`default_nettype wire

// ==== src/line_buffer.sv ====
// Line buffer: two row memories and a sliding 3x3 window with window-complete strobe
`timescale 1ns/100ps
`default_nettype none

module line_buffer
    import cnn_pkg::*;
#(
    parameter int IMG_WIDTH  = 8,
    parameter int IMG_HEIGHT = 6
) (
    input  logic                clock_i,
    input  logic                rst_i,
    // Raster pixel stream
    input  logic [PIX_BITS-1:0] pix_i,
    input  logic                pix_valid_i,
    // Current window and its strobe
    output pix_window_t         window_o,
    output logic                window_valid_o
);

    localparam int COL_BITS = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
    localparam int ROW_BITS = (IMG_HEIGHT > 1) ? $clog2(IMG_HEIGHT) : 1;

    // Row memories, old holds two rows back, prev one row back
    logic [PIX_BITS-1:0] row_old  [IMG_WIDTH];
    logic [PIX_BITS-1:0] row_prev [IMG_WIDTH];

    logic [COL_BITS-1:0] col_q;
    logic [ROW_BITS-1:0] row_q;
    pix_window_t         window_q;
    logic                window_valid_q;
    logic                window_done;

    // Bottom-right corner of a full 3x3 region
    assign window_done = (col_q >= COL_BITS'(KSIZE - 1)) &&
                         (row_q >= ROW_BITS'(KSIZE - 1));

    // Raster position, wraps at the end of the frame
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            col_q          <= '0;
            row_q          <= '0;
            window_valid_q <= 1'b0;
        end else begin
            window_valid_q <= pix_valid_i && window_done;
            if (pix_valid_i) begin
                if (col_q == COL_BITS'(IMG_WIDTH - 1)) begin
                    col_q <= '0;
                    if (row_q == ROW_BITS'(IMG_HEIGHT - 1)) begin
                        row_q <= '0;
                    end else begin
                        row_q <= row_q + 1'b1;
                    end
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    // Column moves up through the row memories
    always_ff @(posedge clock_i) begin
        if (pix_valid_i) begin
            row_old[col_q]  <= row_prev[col_q];
            row_prev[col_q] <= pix_i;
        end
    end

    // Window shifts left, new column enters at the right
    always_ff @(posedge clock_i) begin
        if (pix_valid_i) begin
            for (int r = 0; r < KSIZE; r++) begin
                for (int c = 0; c < KSIZE - 1; c++) begin
                    window_q[r*KSIZE + c] <= window_q[r*KSIZE + c + 1];
                end
            end
            window_q[KSIZE - 1]           <= row_old[col_q];
            window_q[2*KSIZE - 1]         <= row_prev[col_q];
            window_q[NUM_TAPS - 1]        <= pix_i;
        end
    end

    assign window_o       = window_q;
    assign window_valid_o = window_valid_q;

endmodule

`default_nettype wire

// ==== src/weight_arbiter.sv ====
// Weight arbiter: round-robin access of the conv engines to the weight RAM read port
`timescale 1ns/100ps
`default_nettype none

module weight_arbiter
    import cnn_pkg::*;
(
    input  logic                      clock_i,
    input  logic                      rst_i,
    // One bus per engine
    weight_bus_if.arbiter             bus [NUM_ENGINES],
    // RAM read port
    output logic [WT_ADDR_BITS-1:0]   ram_raddr_o,
    input  logic signed [WT_BITS-1:0] ram_rdata_i
);

    localparam int IDX_BITS = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;

    logic [NUM_ENGINES-1:0]  req_vec;
    logic [WT_ADDR_BITS-1:0] addr_vec [NUM_ENGINES];
    logic [NUM_ENGINES-1:0]  gnt;
    logic [IDX_BITS-1:0]     grant_idx;
    // Highest priority engine for the next cycle
    logic [IDX_BITS-1:0]     ptr_q;
    // Engine that gets data back this cycle
    logic [NUM_ENGINES-1:0]  rvalid_q;

    // Flatten the bus array, constant indices only
    for (genvar g = 0; g < NUM_ENGINES; g++) begin : g_bus
        assign req_vec[g]    = bus[g].req;
        assign addr_vec[g]   = bus[g].addr;
        assign bus[g].gnt    = gnt[g];
        // RAM data goes to all, rvalid marks the owner
        assign bus[g].rdata  = ram_rdata_i;
        assign bus[g].rvalid = rvalid_q[g];
    end

    // First requester at or after the pointer wins
    always_comb begin
        int  idx;
        logic found;
        gnt       = '0;
        grant_idx = ptr_q;
        found     = 1'b0;
        for (int k = 0; k < NUM_ENGINES; k++) begin
            idx = (int'(ptr_q) + k) % NUM_ENGINES;
            if (!found && req_vec[idx]) begin
                gnt[idx]  = 1'b1;
                grant_idx = IDX_BITS'(idx);
                found     = 1'b1;
            end
        end
    end

    // Granted engine's address goes to the RAM
    assign ram_raddr_o = addr_vec[grant_idx];

    // Pointer moves past the last grant
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            ptr_q    <= '0;
            rvalid_q <= '0;
        end else begin
            rvalid_q <= gnt;
            if (|gnt) begin
                if (grant_idx == IDX_BITS'(NUM_ENGINES - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= grant_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/weight_bus_if.sv ====
// Weight read bus between one conv engine and the shared weight memory arbiter
`timescale 1ns/100ps
`default_nettype none

interface weight_bus_if
    import cnn_pkg::*;
();

    // Request side, addr held while req is high
    logic                      req;
    logic [WT_ADDR_BITS-1:0]   addr;

    // Grant and return side
    logic                      gnt;
    logic signed [WT_BITS-1:0] rdata;
    // One cycle after gnt
    logic                      rvalid;

    modport requester (
        output req,
        output addr,
        input  gnt,
        input  rdata,
        input  rvalid
    );

    modport arbiter (
        input  req,
        input  addr,
        output gnt,
        output rdata,
        output rvalid
    );

endinterface

`default_nettype wire

// ==== src/weight_ram.sv ====
// Weight RAM: shared kernel storage, host write port and one registered read port
`timescale 1ns/100ps
`default_nettype none

module weight_ram
    import cnn_pkg::*;
(
    input  logic                      clock_i,
    input  logic                      rst_i,
    // Host write port
    input  logic                      we_i,
    input  logic [WT_ADDR_BITS-1:0]   waddr_i,
    input  logic signed [WT_BITS-1:0] wdata_i,
    // Arbitrated read port
    input  logic [WT_ADDR_BITS-1:0]   raddr_i,
    output logic signed [WT_BITS-1:0] rdata_o
);

    // Nine taps per channel
    localparam int WT_DEPTH = NUM_ENGINES * NUM_TAPS;

    logic signed [WT_BITS-1:0] mem [WT_DEPTH];

    // Writes outside the kernel area are dropped
    always_ff @(posedge clock_i) begin
        if (we_i && (waddr_i < WT_ADDR_BITS'(WT_DEPTH))) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (raddr_i < WT_ADDR_BITS'(WT_DEPTH)) begin
            rdata_o <= mem[raddr_i];
        end else begin
            rdata_o <= '0;
        end
    end

endmodule

`default_nettype wire
